// File: logic/exe_pkg.sv
`default_nettype none

package exe_pkg;

    // the immediate word, decoded both as one value and as r-type fields
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } imm_fields_t;

    typedef union packed {
        logic [15:0] word;
        imm_fields_t f;
    } imm_word_t;

    // one-hot alu op bits
    localparam int ALU_W    = 12;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // one-hot load/store op bits
    localparam int LS_W   = 8;
    localparam int LS_SW  = 0;
    localparam int LS_SB  = 1;
    localparam int LS_SH  = 2;
    localparam int LS_SWL = 3;
    localparam int LS_SWR = 4;
    localparam int LS_LW  = 5;
    localparam int LS_LH  = 6;
    localparam int LS_LHU = 7;

    // cp0 cause codes
    localparam int EXC_W = 5;
    localparam logic [EXC_W-1:0] EXC_NONE = 5'd0;
    localparam logic [EXC_W-1:0] EXC_ADEL = 5'd4;
    localparam logic [EXC_W-1:0] EXC_ADES = 5'd5;
    localparam logic [EXC_W-1:0] EXC_OV   = 5'd12;

    localparam int REG_ADDR_W = 5;
    localparam int LANES      = 4;

endpackage

`default_nettype wire

// File: logic/exe_operand_alu.sv
`default_nettype none

module exe_operand_alu (
    input  wire logic [exe_pkg::ALU_W-1:0] alu_op,
    input  wire logic                      src1_is_sa,
    input  wire logic                      src1_is_pc,
    input  wire logic                      src2_is_imm,
    input  wire logic                      src2_is_uimm,
    input  wire logic                      src2_is_8,
    input  wire exe_pkg::imm_word_t        imm,
    input  wire logic [31:0]               rs_value,
    input  wire logic [31:0]               rt_value,
    input  wire logic [31:0]               pc,
    output logic      [31:0]               alu_result,
    output logic                           overflow
);

    logic [31:0] src1;
    logic [31:0] src2;

    logic [31:0] adder_b;
    logic        adder_cin;
    logic [31:0] adder_sum;

    logic [31:0] slt_result;
    logic [31:0] sltu_result;
    logic [31:0] sll_result;
    logic [31:0] srl_result;
    logic [31:0] sra_result;
    logic [31:0] lui_result;
    logic [4:0]  shamt;

    // operand 1: shift amount, pc, or rs
    assign src1 = src1_is_sa ? {27'b0, imm.f.sa} :
                  src1_is_pc ? pc :
                               rs_value;

    // operand 2: sign-extended, zero-extended, 8, or rt
    assign src2 = src2_is_imm  ? {{16{imm.word[15]}}, imm.word} :
                  src2_is_uimm ? {16'b0, imm.word} :
                  src2_is_8    ? 32'd8 :
                                 rt_value;

    // shared adder, subtract by inverting b
    assign adder_b   = alu_op[exe_pkg::ALU_SUB] ? ~src2 : src2;
    assign adder_cin = alu_op[exe_pkg::ALU_SUB];
    assign adder_sum = src1 + adder_b + {31'b0, adder_cin};

    // signed overflow when both inputs agree in sign and the sum does not
    assign overflow = (alu_op[exe_pkg::ALU_ADD] | alu_op[exe_pkg::ALU_SUB])
                    & (src1[31] == adder_b[31])
                    & (adder_sum[31] != src1[31]);

    assign slt_result  = {31'b0, $signed(src1) < $signed(src2)};
    assign sltu_result = {31'b0, src1 < src2};

    assign shamt      = src1[4:0];
    assign sll_result = src2 << shamt;
    assign srl_result = src2 >> shamt;
    assign sra_result = $signed(src2) >>> shamt;
    assign lui_result = {src2[15:0], 16'b0};

    always_comb begin
        alu_result = ({32{alu_op[exe_pkg::ALU_ADD]}}  & adder_sum)
                   | ({32{alu_op[exe_pkg::ALU_SUB]}}  & adder_sum)
                   | ({32{alu_op[exe_pkg::ALU_SLT]}}  & slt_result)
                   | ({32{alu_op[exe_pkg::ALU_SLTU]}} & sltu_result)
                   | ({32{alu_op[exe_pkg::ALU_AND]}}  & (src1 & src2))
                   | ({32{alu_op[exe_pkg::ALU_NOR]}}  & ~(src1 | src2))
                   | ({32{alu_op[exe_pkg::ALU_OR]}}   & (src1 | src2))
                   | ({32{alu_op[exe_pkg::ALU_XOR]}}  & (src1 ^ src2))
                   | ({32{alu_op[exe_pkg::ALU_SLL]}}  & sll_result)
                   | ({32{alu_op[exe_pkg::ALU_SRL]}}  & srl_result)
                   | ({32{alu_op[exe_pkg::ALU_SRA]}}  & sra_result)
                   | ({32{alu_op[exe_pkg::ALU_LUI]}}  & lui_result);
    end

endmodule

`default_nettype wire

// File: logic/exe_stage_reg.sv
`default_nettype none

module exe_stage_reg (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           flush,
    input  wire logic                           ds_valid,
    input  wire logic                           ms_allowin,
    output logic                                es_allowin,
    output logic                                valid,
    input  wire logic [31:0]                    alu_result,
    input  wire logic [31:0]                    rt_value,
    input  wire logic [31:0]                    pc,
    input  wire logic [exe_pkg::REG_ADDR_W-1:0] dest,
    input  wire logic                           gr_we,
    input  wire logic                           mem_we,
    input  wire logic                           ov_ex,
    input  wire logic [exe_pkg::LS_W-1:0]       ls_op,
    input  wire logic                           ds_ex,
    input  wire logic [exe_pkg::EXC_W-1:0]      ds_excode,
    output logic      [31:0]                    r_alu_result,
    output logic      [31:0]                    r_rt_value,
    output logic      [31:0]                    r_pc,
    output logic      [exe_pkg::REG_ADDR_W-1:0] r_dest,
    output logic                                r_gr_we,
    output logic                                r_mem_we,
    output logic                                r_ov_ex,
    output logic      [exe_pkg::LS_W-1:0]       r_ls_op,
    output logic                                r_ds_ex,
    output logic      [exe_pkg::EXC_W-1:0]      r_ds_excode
);

    logic accept;

    // single-entry stage, ready to take a new one when empty or draining
    assign es_allowin = !valid || ms_allowin;
    assign accept     = ds_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (es_allowin) begin
            valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_alu_result <= alu_result;
            r_rt_value   <= rt_value;
            r_pc         <= pc;
            r_dest       <= dest;
            r_gr_we      <= gr_we;
            r_mem_we     <= mem_we;
            r_ov_ex      <= ov_ex;
            r_ls_op      <= ls_op;
            r_ds_ex      <= ds_ex;
            r_ds_excode  <= ds_excode;
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_store_unit.sv
`default_nettype none

module exe_store_unit (
    input  wire logic                      valid,
    input  wire logic                      mem_we,
    input  wire logic                      ov_ex,
    input  wire logic                      ds_ex,
    input  wire logic                      later_exc,
    input  wire logic [exe_pkg::LS_W-1:0]  ls_op,
    input  wire logic [exe_pkg::EXC_W-1:0] ds_excode,
    input  wire logic [31:0]               addr,
    input  wire logic [31:0]               rt_value,
    output logic      [exe_pkg::LANES-1:0] data_sram_wen,
    output logic      [31:0]               data_sram_addr,
    output logic      [31:0]               data_sram_wdata,
    output logic                           es_ex,
    output logic      [exe_pkg::EXC_W-1:0] es_excode
);

    logic [1:0]                vaddr;
    logic [exe_pkg::LANES-1:0] byte_wen;
    logic                      load_adde;
    logic                      store_adde;

    assign vaddr          = addr[1:0];
    assign data_sram_addr = {addr[31:2], 2'b00};

    // lane enables and lane-aligned data per store kind
    always_comb begin
        byte_wen        = '0;
        data_sram_wdata = rt_value;
        if (ls_op[exe_pkg::LS_SW]) begin
            byte_wen = 4'b1111;
        end else if (ls_op[exe_pkg::LS_SB]) begin
            byte_wen        = 4'b0001 << vaddr;
            data_sram_wdata = {4{rt_value[7:0]}};
        end else if (ls_op[exe_pkg::LS_SH]) begin
            byte_wen        = vaddr[1] ? 4'b1100 : 4'b0011;
            data_sram_wdata = {2{rt_value[15:0]}};
        end else if (ls_op[exe_pkg::LS_SWL]) begin
            // upper bytes of rt land at and below the address
            case (vaddr)
                2'b00:   byte_wen = 4'b0001;
                2'b01:   byte_wen = 4'b0011;
                2'b10:   byte_wen = 4'b0111;
                default: byte_wen = 4'b1111;
            endcase
            data_sram_wdata = rt_value >> {~vaddr, 3'b000};
        end else if (ls_op[exe_pkg::LS_SWR]) begin
            // lower bytes of rt land at and above the address
            case (vaddr)
                2'b00:   byte_wen = 4'b1111;
                2'b01:   byte_wen = 4'b1110;
                2'b10:   byte_wen = 4'b1100;
                default: byte_wen = 4'b1000;
            endcase
            data_sram_wdata = rt_value << {vaddr, 3'b000};
        end
    end

    // a later stage holding an exception cancels the write
    assign data_sram_wen = (valid && mem_we && !later_exc) ? byte_wen : '0;

    assign store_adde = (ls_op[exe_pkg::LS_SW] && (vaddr != 2'b00))
                      | (ls_op[exe_pkg::LS_SH] && vaddr[0]);
    assign load_adde  = (ls_op[exe_pkg::LS_LW] && (vaddr != 2'b00))
                      | (ls_op[exe_pkg::LS_LH] && vaddr[0])
                      | (ls_op[exe_pkg::LS_LHU] && vaddr[0]);

    // decode exception wins, then overflow, load, store
    always_comb begin
        es_ex     = 1'b0;
        es_excode = exe_pkg::EXC_NONE;
        if (valid) begin
            es_ex = ds_ex | ov_ex | load_adde | store_adde;
            if (ds_ex) begin
                es_excode = ds_excode;
            end else if (ov_ex) begin
                es_excode = exe_pkg::EXC_OV;
            end else if (load_adde) begin
                es_excode = exe_pkg::EXC_ADEL;
            end else if (store_adde) begin
                es_excode = exe_pkg::EXC_ADES;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/exe_stage_top.sv
`default_nettype none

module exe_stage_top (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           ds_valid,
    input  wire logic                           ms_allowin,
    input  wire logic                           flush,
    input  wire logic                           later_exc,
    input  wire logic [exe_pkg::ALU_W-1:0]      alu_op,
    input  wire logic                           src1_is_sa,
    input  wire logic                           src1_is_pc,
    input  wire logic                           src2_is_imm,
    input  wire logic                           src2_is_uimm,
    input  wire logic                           src2_is_8,
    input  wire exe_pkg::imm_word_t             imm,
    input  wire logic [31:0]                    rs_value,
    input  wire logic [31:0]                    rt_value,
    input  wire logic [31:0]                    pc,
    input  wire logic                           gr_we,
    input  wire logic                           mem_we,
    input  wire logic                           overflow_inst,
    input  wire logic [exe_pkg::REG_ADDR_W-1:0] dest,
    input  wire logic [exe_pkg::LS_W-1:0]       ls_op,
    input  wire logic                           ds_ex,
    input  wire logic [exe_pkg::EXC_W-1:0]      ds_excode,
    output logic                                es_allowin,
    output logic                                es_to_ms_valid,
    output logic      [31:0]                    es_result,
    output logic      [exe_pkg::REG_ADDR_W-1:0] es_dest,
    output logic                                es_gr_we,
    output logic      [31:0]                    es_pc,
    output logic                                es_ex,
    output logic      [exe_pkg::EXC_W-1:0]      es_excode,
    output logic      [exe_pkg::LANES-1:0]      data_sram_wen,
    output logic      [31:0]                    data_sram_addr,
    output logic      [31:0]                    data_sram_wdata
);

    logic [31:0]                alu_result;
    logic                       overflow;
    logic [31:0]                r_rt_value;
    logic                       r_mem_we;
    logic                       r_ov_ex;
    logic [exe_pkg::LS_W-1:0]   r_ls_op;
    logic                       r_ds_ex;
    logic [exe_pkg::EXC_W-1:0]  r_ds_excode;

    exe_operand_alu u_operand_alu (
        .alu_op       (alu_op),
        .src1_is_sa   (src1_is_sa),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .src2_is_uimm (src2_is_uimm),
        .src2_is_8    (src2_is_8),
        .imm          (imm),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .pc           (pc),
        .alu_result   (alu_result),
        .overflow     (overflow)
    );

    // overflow traps only for the signed add and sub forms
    exe_stage_reg u_stage_reg (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .ds_valid     (ds_valid),
        .ms_allowin   (ms_allowin),
        .es_allowin   (es_allowin),
        .valid        (es_to_ms_valid),
        .alu_result   (alu_result),
        .rt_value     (rt_value),
        .pc           (pc),
        .dest         (dest),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .ov_ex        (overflow & overflow_inst),
        .ls_op        (ls_op),
        .ds_ex        (ds_ex),
        .ds_excode    (ds_excode),
        .r_alu_result (es_result),
        .r_rt_value   (r_rt_value),
        .r_pc         (es_pc),
        .r_dest       (es_dest),
        .r_gr_we      (es_gr_we),
        .r_mem_we     (r_mem_we),
        .r_ov_ex      (r_ov_ex),
        .r_ls_op      (r_ls_op),
        .r_ds_ex      (r_ds_ex),
        .r_ds_excode  (r_ds_excode)
    );

    exe_store_unit u_store_unit (
        .valid           (es_to_ms_valid),
        .mem_we          (r_mem_we),
        .ov_ex           (r_ov_ex),
        .ds_ex           (r_ds_ex),
        .later_exc       (later_exc),
        .ls_op           (r_ls_op),
        .ds_excode       (r_ds_excode),
        .addr            (es_result),
        .rt_value        (r_rt_value),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .es_ex           (es_ex),
        .es_excode       (es_excode)
    );

endmodule

`default_nettype wire

// File: sim/exe_stage_assert.sv
`default_nettype none

module exe_stage_assert (
    input wire logic                      clk,
    input wire logic                      reset,
    input wire logic                      flush,
    input wire logic                      ms_allowin,
    input wire logic                      es_to_ms_valid,
    input wire logic                      es_ex,
    input wire logic [exe_pkg::LANES-1:0] data_sram_wen
);
    timeunit 1ns;
    timeprecision 1ps;

    // memory writes only come from a live instruction
    wen_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (data_sram_wen != '0) |-> es_to_ms_valid)
        else $error("memory write enabled while the stage is empty");

    // a stalled instruction stays put unless flushed
    stall_holds_valid: assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && !ms_allowin && !flush) |=> es_to_ms_valid)
        else $error("stalled instruction vanished without a flush");

    no_exc_when_empty: assert property (@(posedge clk) disable iff (reset)
        !es_to_ms_valid |-> !es_ex)
        else $error("exception flagged while the stage is empty");

endmodule

`default_nettype wire

// File: sim/exe_stage_tb.sv
`default_nettype none

module exe_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES  = 4000;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  dest;
        logic        gr_we;
        logic [31:0] pc;
        logic [3:0]  wen;
        logic [31:0] wdata;
        logic        ex;
        logic [4:0]  excode;
    } exp_rec_t;

    logic clk, reset, ds_valid, ms_allowin, flush, later_exc;
    logic [exe_pkg::ALU_W-1:0] alu_op;
    logic src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8;
    exe_pkg::imm_word_t imm;
    logic [31:0] rs_value, rt_value, pc;
    logic gr_we, mem_we, overflow_inst, ds_ex;
    logic [4:0] dest, ds_excode;
    logic [exe_pkg::LS_W-1:0] ls_op;
    logic es_allowin, es_to_ms_valid, es_gr_we, es_ex;
    logic [31:0] es_result, es_pc, data_sram_addr, data_sram_wdata;
    logic [4:0] es_dest, es_excode;
    logic [3:0] data_sram_wen;

    exp_rec_t exp_q[$];
    logic [31:0] rng_state;
    logic checking_on;
    int value_errors, protocol_errors, timeout_errors, waited;

    exe_stage_top i_exe_stage_top (.*);

    bind exe_stage_top exe_stage_assert u_assert (
        .clk(clk), .reset(reset), .flush(flush), .ms_allowin(ms_allowin),
        .es_to_ms_valid(es_to_ms_valid), .es_ex(es_ex), .data_sram_wen(data_sram_wen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected stage output for the inputs now on the decode side
    function automatic exp_rec_t ref_execute();
        exp_rec_t rec;
        logic [31:0] s1, s2;
        logic [32:0] wide;
        logic [1:0] va;
        logic ov, adel, ades;
        int a;
        rec = '0;
        ov = 1'b0;
        s1 = src1_is_sa ? {27'b0, imm.f.sa} : (src1_is_pc ? pc : rs_value);
        s2 = src2_is_imm ? {{16{imm.word[15]}}, imm.word} :
             src2_is_uimm ? {16'b0, imm.word} : (src2_is_8 ? 32'd8 : rt_value);
        if (alu_op[exe_pkg::ALU_ADD] || alu_op[exe_pkg::ALU_SUB]) begin
            if (alu_op[exe_pkg::ALU_ADD])
                wide = {s1[31], s1} + {s2[31], s2};
            else
                wide = {s1[31], s1} - {s2[31], s2};
            rec.result = wide[31:0];
            ov = wide[32] != wide[31];
        end
        else if (alu_op[exe_pkg::ALU_SLT])  rec.result = {31'b0, $signed(s1) < $signed(s2)};
        else if (alu_op[exe_pkg::ALU_SLTU]) rec.result = {31'b0, s1 < s2};
        else if (alu_op[exe_pkg::ALU_AND])  rec.result = s1 & s2;
        else if (alu_op[exe_pkg::ALU_NOR])  rec.result = ~(s1 | s2);
        else if (alu_op[exe_pkg::ALU_OR])   rec.result = s1 | s2;
        else if (alu_op[exe_pkg::ALU_XOR])  rec.result = s1 ^ s2;
        else if (alu_op[exe_pkg::ALU_SLL])  rec.result = s2 << s1[4:0];
        else if (alu_op[exe_pkg::ALU_SRL])  rec.result = s2 >> s1[4:0];
        else if (alu_op[exe_pkg::ALU_SRA])  rec.result = $signed(s2) >>> s1[4:0];
        else if (alu_op[exe_pkg::ALU_LUI])  rec.result = {s2[15:0], 16'b0};
        rec.dest = dest;
        rec.gr_we = gr_we;
        rec.pc = pc;
        va = rec.result[1:0];
        a = int'(va);
        // swl and swr split rt around the address on little-endian lanes
        for (int i = 0; i < 4; i++) begin
            if (ls_op[exe_pkg::LS_SW]) begin
                rec.wen[i] = 1'b1;
                rec.wdata[8*i +: 8] = rt_value[8*i +: 8];
            end else if (ls_op[exe_pkg::LS_SB]) begin
                rec.wen[i] = (i == a);
                rec.wdata[8*i +: 8] = rt_value[7:0];
            end else if (ls_op[exe_pkg::LS_SH]) begin
                rec.wen[i] = (i / 2) == (a / 2);
                rec.wdata[8*i +: 8] = rt_value[8*(i%2) +: 8];
            end else if (ls_op[exe_pkg::LS_SWL] && i <= a) begin
                rec.wen[i] = 1'b1;
                rec.wdata[8*i +: 8] = rt_value[8*(i+3-a) +: 8];
            end else if (ls_op[exe_pkg::LS_SWR] && i >= a) begin
                rec.wen[i] = 1'b1;
                rec.wdata[8*i +: 8] = rt_value[8*(i-a) +: 8];
            end
        end
        if (!mem_we)
            rec.wen = 4'b0;
        ades = (ls_op[exe_pkg::LS_SW] && va != 2'b00) || (ls_op[exe_pkg::LS_SH] && va[0]);
        adel = (ls_op[exe_pkg::LS_LW] && va != 2'b00)
            || ((ls_op[exe_pkg::LS_LH] || ls_op[exe_pkg::LS_LHU]) && va[0]);
        ov = ov && overflow_inst;
        rec.ex = ds_ex || ov || adel || ades;
        rec.excode = ds_ex ? ds_excode : ov ? exe_pkg::EXC_OV :
                     adel ? exe_pkg::EXC_ADEL : ades ? exe_pkg::EXC_ADES : exe_pkg::EXC_NONE;
        return rec;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_cycle();
        exp_rec_t rec;
        logic [31:0] mask;
        compare_field("es_allowin", {31'b0, es_allowin},
                      {31'b0, exp_q.size() == 0 || ms_allowin});
        assert (es_to_ms_valid == (exp_q.size() != 0)) else begin
            $display("at %0t the stage valid bit is %b while %0d instructions are expected",
                     $time, es_to_ms_valid, exp_q.size());
            protocol_errors++;
        end
        if (es_to_ms_valid && exp_q.size() != 0) begin
            rec = exp_q[0];
            for (int i = 0; i < 4; i++)
                mask[8*i +: 8] = {8{rec.wen[i]}};
            compare_field("es_result", es_result, rec.result);
            compare_field("es_dest", {27'b0, es_dest}, {27'b0, rec.dest});
            compare_field("es_gr_we", {31'b0, es_gr_we}, {31'b0, rec.gr_we});
            compare_field("es_pc", es_pc, rec.pc);
            compare_field("es_ex", {31'b0, es_ex}, {31'b0, rec.ex});
            compare_field("es_excode", {27'b0, es_excode}, {27'b0, rec.excode});
            compare_field("data_sram_addr", data_sram_addr, {rec.result[31:2], 2'b00});
            compare_field("data_sram_wen", {28'b0, data_sram_wen},
                          {28'b0, later_exc ? 4'b0 : rec.wen});
            compare_field("data_sram_wdata", data_sram_wdata & mask, rec.wdata & mask);
        end else begin
            compare_field("idle data_sram_wen", {28'b0, data_sram_wen}, 32'd0);
            compare_field("idle es_ex", {31'b0, es_ex}, 32'd0);
        end
        if (flush) begin
            exp_q.delete();
        end else begin
            if (es_to_ms_valid && ms_allowin && exp_q.size() != 0)
                void'(exp_q.pop_front());
            if (ds_valid && es_allowin)
                exp_q.push_back(ref_execute());
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            #5;
            if (checking_on)
                check_cycle();
        end
    end

    task automatic drive_random_cycle();
        logic [31:0] r, r2;
        int k;
        r = next_random();
        r2 = next_random();
        k = int'(r2 % 12);
        for (int i = 0; i < exe_pkg::ALU_W; i++)
            alu_op[i] = (i == k);
        k = int'(r2[15:8] % 10);
        for (int i = 0; i < exe_pkg::LS_W; i++)
            ls_op[i] = (i == k);
        mem_we = k <= 4;
        {src1_is_sa, src1_is_pc} = {r[1:0] == 2'b00, r[3:2] == 2'b00};
        {src2_is_imm, src2_is_uimm, src2_is_8} = {r[5:4] == 2'b00, r[7:6] == 2'b00,
                                                  r[9:8] == 2'b00};
        {gr_we, overflow_inst} = r[11:10];
        ds_ex = r[14:12] == 3'b000;
        ds_excode = r[19:15];
        ms_allowin = r[21:20] != 2'b00;
        flush = r[26:22] == 5'b00000;
        later_exc = r[29:27] == 3'b000;
        ds_valid = r[31:30] != 2'b00;
        dest = r2[20:16];
        r = next_random();
        imm.word = r[31:16];
        rs_value = next_random();
        rt_value = next_random();
        pc = next_random();
    endtask

    initial begin
        rng_state = 32'h5e55;
        checking_on = 1'b0;
        {reset, ds_valid, ms_allowin, flush, later_exc} = 5'b11000;
        {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8} = 5'b0;
        {alu_op, ls_op, imm, rs_value, rt_value, pc} = '0;
        {gr_we, mem_we, overflow_inst, ds_ex, dest, ds_excode} = '0;
        // a stalled faulting store is offered while reset holds the stage empty
        ls_op[exe_pkg::LS_SW] = 1'b1;
        mem_we = 1'b1;
        ds_ex = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        ds_valid = 1'b0;
        #2;
        compare_field("reset es_to_ms_valid", {31'b0, es_to_ms_valid}, 32'd0);
        compare_field("reset data_sram_wen", {28'b0, data_sram_wen}, 32'd0);
        compare_field("reset es_ex", {31'b0, es_ex}, 32'd0);
        compare_field("reset es_allowin", {31'b0, es_allowin}, 32'd1);
        checking_on = 1'b1;
        repeat (NUM_CYCLES) begin
            @(negedge clk);
            drive_random_cycle();
        end
        @(negedge clk);
        {ds_valid, ms_allowin, flush, later_exc} = 4'b0100;
        waited = 0;
        while ((exp_q.size() != 0 || es_to_ms_valid) && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || es_to_ms_valid) begin
            $display("timeout: the stage did not drain within %0d cycles", DRAIN_LIMIT);
            timeout_errors++;
        end
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
logic/exe_pkg.sv
logic/exe_operand_alu.sv
logic/exe_stage_reg.sv
logic/exe_store_unit.sv
logic/exe_stage_top.sv
sim/exe_stage_assert.sv
sim/exe_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module exe_stage_tb \
    -f tb.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vexe_stage_tb > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "FAIL: see errors above" "$SIM_LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
